// File: include/acq_macros.svh
`ifndef ACQ_MACROS_SVH
`define ACQ_MACROS_SVH

// --------------------
// Array size
// --------------------
`define ACQ_NUM_ANT 4        // Antennas in the bench

// --------------------
// Symbol window
// --------------------
`define ACQ_WINDOW 12        // Sample ticks per symbol
`define ACQ_SAMPLE_PHASE 6   // Stagger sample point, also the mid-eye distance

// --------------------
// Skew limits
// --------------------
`define ACQ_MAX_OFFSET 4     // Largest cable offset in ticks
`define ACQ_JITTER_BITS 1    // Jitter is 0 or 1 tick

// Consistent edges seen before the tracker trusts its phase
`define ACQ_LOCK_EDGES 3

`endif

// File: hdl/acq_signal_pkg.sv
`include "acq_macros.svh"

package acq_signal_pkg;

   // --------------------
   // Antenna side
   // --------------------

   // One sign bit per antenna, bit i belongs to antenna i
   typedef logic [`ACQ_NUM_ANT-1:0] ant_bits_t;

   // --------------------
   // Window timing
   // --------------------

   // Tick within the symbol window, 0 to ACQ_WINDOW-1
   typedef logic [3:0] tick_t;

   // Phase shift in ticks, used for both cable offset and jitter
   // Unsigned, only ever pushes the sample point earlier
   typedef logic [2:0] phase_t;

endpackage

// File: hdl/acq_ctrl_pkg.sv
package acq_ctrl_pkg;

   // --------------------
   // Jitter source
   // --------------------

   // Galois LFSR state, nonzero after reset
   typedef logic [15:0] lfsr_t;

   // --------------------
   // Phase tracker
   // --------------------

   typedef enum logic {
      TRK_SEARCH, // Counting consistent edges
      TRK_LOCKED  // Sampling at mid-eye
   } track_state_t;

endpackage

// File: hdl/jitter_lfsr.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module jitter_lfsr #(
   parameter acq_ctrl_pkg::lfsr_t SEED = 16'hace1 // Must not be zero
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  step,   // Window wrap, already qualified by ce
   input  logic                  enable,
   output acq_signal_pkg::phase_t jitter
);

   // x^16 + x^14 + x^13 + x^11 + 1, maximal length
   localparam acq_ctrl_pkg::lfsr_t TAPS = 16'hb400;
   localparam int PAD_W = $bits(acq_signal_pkg::phase_t) - `ACQ_JITTER_BITS;

   acq_ctrl_pkg::lfsr_t state;

   // Shift right, fold taps back in when the dropped bit is set
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= SEED;
      end else if (step) begin
         state <= {1'b0, state[15:1]} ^ (state[0] ? TAPS : '0);
      end
   end

   // Low bits form the jitter, held for the whole window
   assign jitter = enable ? {{PAD_W{1'b0}}, state[`ACQ_JITTER_BITS-1:0]} : '0;

endmodule

// File: hdl/signal_stagger.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

// Resamples one oversampled sign stream once per symbol window.
// The sample point moves earlier by the cable offset plus the jitter,
// so the output edge lands at a skewed and slightly wandering tick.
module signal_stagger (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   ce,
   input  acq_signal_pkg::tick_t  tick,   // Shared window counter
   input  acq_signal_pkg::phase_t offset, // Static cable offset
   input  acq_signal_pkg::phase_t jitter, // Per-window wander
   input  logic                   d,      // Oversampled antenna sign
   output logic                   q       // Skewed stream
);

   // --------------------
   // Offset limit
   // --------------------

   acq_signal_pkg::phase_t offset_lim;

   // Out-of-range config saturates rather than wrapping
   assign offset_lim = (offset > acq_signal_pkg::phase_t'(`ACQ_MAX_OFFSET)) ?
                       acq_signal_pkg::phase_t'(`ACQ_MAX_OFFSET) : offset;

   // --------------------
   // Sample phase
   // --------------------

   logic [4:0] phase_sum; // One bit wider than the tick
   logic       take;

   // Tick 11 plus the largest skew still fits in five bits
   assign phase_sum = 5'(tick) + 5'(offset_lim) + 5'(jitter);

   // Hits exactly once per window
   assign take = ce && (phase_sum == 5'(`ACQ_SAMPLE_PHASE));

   // --------------------
   // Output register
   // --------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         q <= 1'b0;
      end else if (take) begin
         q <= d;   // New symbol value, visible the cycle after
      end
      // Held for the rest of the window
   end

endmodule

// File: hdl/edge_phase_tracker.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

// Finds where the incoming edges sit inside the symbol window, locks
// once they agree, and samples half a window away from them.
module edge_phase_tracker (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  ce,
   input  acq_signal_pkg::tick_t tick,     // Shared window counter
   input  logic                  d,        // Skewed stream
   output logic                  bit_out,  // Recovered symbol
   output logic                  bit_valid, // One-cycle pulse per window
   output logic                  locked
);

   localparam int CNT_W = $clog2(`ACQ_LOCK_EDGES + 1);
   localparam acq_signal_pkg::tick_t WIN = acq_signal_pkg::tick_t'(`ACQ_WINDOW);

   // Distance between two ticks around the window circle
   function automatic acq_signal_pkg::tick_t circ_dist(
      input acq_signal_pkg::tick_t a,
      input acq_signal_pkg::tick_t b
   );
      acq_signal_pkg::tick_t diff;
      diff = (a >= b) ? a - b : b - a;
      return (diff > WIN / 2) ? WIN - diff : diff;
   endfunction

   // --------------------
   // Edge detect
   // --------------------

   logic                      d_prev;     // Value at the previous ce
   logic                      edge_seen;
   acq_signal_pkg::tick_t     edge_pos;   // Reference edge tick
   acq_signal_pkg::tick_t     edge_dist;
   logic [CNT_W-1:0]          edge_cnt;   // Consistent edges so far
   logic [4:0]                mid_sum;
   acq_signal_pkg::tick_t     mid_tick;   // Mid-eye for the current edge
   acq_signal_pkg::tick_t     sample_tick;
   acq_ctrl_pkg::track_state_t state;

   assign edge_seen = ce && (d != d_prev);
   assign edge_dist = circ_dist(tick, edge_pos);

   // Edge plus half a window, modulo the window
   assign mid_sum  = 5'(tick) + 5'(`ACQ_SAMPLE_PHASE);
   assign mid_tick = (mid_sum >= 5'(`ACQ_WINDOW)) ?
                     acq_signal_pkg::tick_t'(mid_sum - 5'(`ACQ_WINDOW)) :
                     acq_signal_pkg::tick_t'(mid_sum);

   // --------------------
   // Lock FSM
   // --------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         d_prev      <= 1'b0;
         edge_pos    <= '0;
         edge_cnt    <= '0;
         sample_tick <= '0;
         state       <= acq_ctrl_pkg::TRK_SEARCH;
      end else if (ce) begin
         d_prev <= d;
         if (edge_seen) begin
            case (state)
               acq_ctrl_pkg::TRK_SEARCH: begin
                  edge_pos <= tick; // Follow the latest edge
                  if (edge_cnt != '0 && edge_dist <= 4'd1) begin
                     if (edge_cnt == CNT_W'(`ACQ_LOCK_EDGES - 1)) begin
                        state       <= acq_ctrl_pkg::TRK_LOCKED;
                        sample_tick <= mid_tick;
                        edge_cnt    <= '0;
                     end else begin
                        edge_cnt <= edge_cnt + 1'b1;
                     end
                  end else begin
                     edge_cnt <= CNT_W'(1); // Restart the run here
                  end
               end
               acq_ctrl_pkg::TRK_LOCKED: begin
                  // Jitter moves edges by one tick, more means the phase slipped
                  if (edge_dist > 4'd2) begin
                     state    <= acq_ctrl_pkg::TRK_SEARCH;
                     edge_pos <= tick;
                     edge_cnt <= CNT_W'(1);
                  end
               end
               default: state <= acq_ctrl_pkg::TRK_SEARCH;
            endcase
         end
      end
   end

   // --------------------
   // Bit output
   // --------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         bit_out   <= 1'b0;
         bit_valid <= 1'b0;
      end else begin
         bit_valid <= 1'b0; // Pulse only
         if (ce && state == acq_ctrl_pkg::TRK_LOCKED && tick == sample_tick) begin
            bit_out   <= d;
            bit_valid <= 1'b1;
         end
      end
   end

   assign locked = (state == acq_ctrl_pkg::TRK_LOCKED);

endmodule

// File: hdl/acquire_top.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module acquire_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       ce,        // Sample tick strobe
   input  acq_signal_pkg::ant_bits_t  ant_in,    // Oversampled signs
   input  acq_signal_pkg::phase_t [`ACQ_NUM_ANT-1:0] cfg_offset,
   input  logic                       jitter_en,
   output wire acq_signal_pkg::ant_bits_t stag_out,
   output wire acq_signal_pkg::ant_bits_t bit_out,
   output wire acq_signal_pkg::ant_bits_t bit_valid,
   output wire acq_signal_pkg::ant_bits_t locked
);

   // --------------------
   // Window counter
   // --------------------

   acq_signal_pkg::tick_t tick;
   logic                  win_wrap;

   // Last tick of the window, on a real sample
   assign win_wrap = ce && (tick == acq_signal_pkg::tick_t'(`ACQ_WINDOW - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         tick <= '0;
      end else if (ce) begin
         tick <= win_wrap ? '0 : tick + 4'd1;
      end
   end

   // --------------------
   // Per-antenna chains
   // --------------------

   for (genvar i = 0; i < `ACQ_NUM_ANT; i++) begin : g_ant
      acq_signal_pkg::phase_t jitter;

      // Distinct seeds so the antennas wander independently
      jitter_lfsr #(
         .SEED(acq_ctrl_pkg::lfsr_t'(16'hace1 + i * 16'h3b5d))
      ) jitter_lfsr_inst (
         .clk    (clk),
         .rst    (rst),
         .step   (win_wrap),
         .enable (jitter_en),
         .jitter (jitter)
      );

      signal_stagger signal_stagger_inst (
         .clk    (clk),
         .rst    (rst),
         .ce     (ce),
         .tick   (tick),
         .offset (cfg_offset[i]),
         .jitter (jitter),
         .d      (ant_in[i]),
         .q      (stag_out[i])
      );

      // Tracker sees the skewed stream, as a real receiver would
      edge_phase_tracker edge_phase_tracker_inst (
         .clk       (clk),
         .rst       (rst),
         .ce        (ce),
         .tick      (tick),
         .d         (stag_out[i]),
         .bit_out   (bit_out[i]),
         .bit_valid (bit_valid[i]),
         .locked    (locked[i])
      );
   end

endmodule

// File: tb/acquire_assertions.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module acquire_assertions (
   input logic                      clk,
   input logic                      rst,
   input logic                      ce,
   input acq_signal_pkg::tick_t     tick,      // DUT window counter
   input acq_signal_pkg::ant_bits_t stag_out,
   input acq_signal_pkg::ant_bits_t bit_out,
   input acq_signal_pkg::ant_bits_t bit_valid,
   input acq_signal_pkg::ant_bits_t locked
);

   localparam acq_signal_pkg::tick_t FIRST_TAKE =
      acq_signal_pkg::tick_t'(`ACQ_SAMPLE_PHASE - `ACQ_MAX_OFFSET - 1);
   localparam acq_signal_pkg::tick_t LAST_TAKE = acq_signal_pkg::tick_t'(`ACQ_SAMPLE_PHASE);

   int fail_cnt = 0; // Failed assertions so far

   // --------------------
   // Shared timing
   // --------------------

   a_tick_range: assert property (@(posedge clk) tick < acq_signal_pkg::tick_t'(`ACQ_WINDOW))
      else begin
         fail_cnt++;
         $error("window counter out of range");
      end

   // Everything clean right after reset
   a_reset_state: assert property (@(posedge clk) rst |=> (stag_out == '0 && bit_out == '0
                                   && bit_valid == '0 && locked == '0 && tick == '0))
      else begin
         fail_cnt++;
         $error("outputs not cleared by reset");
      end

   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
                                  !ce |=> ($stable(stag_out) && $stable(bit_out)
                                  && $stable(locked) && bit_valid == '0))
      else begin
         fail_cnt++;
         $error("output moved on an edge without ce");
      end

   // --------------------
   // Per antenna
   // --------------------

   for (genvar i = 0; i < `ACQ_NUM_ANT; i++) begin : g_ant
      a_pulse_width: assert property (@(posedge clk) disable iff (rst)
                                      bit_valid[i] |=> !bit_valid[i])
         else begin
            fail_cnt++;
            $error("bit_valid[%0d] wider than one cycle", i);
         end

      // Pulse carries the stream value seen at the sample ce
      a_pulse_data: assert property (@(posedge clk) disable iff (rst)
                                     bit_valid[i] |-> bit_out[i] == $past(stag_out[i]))
         else begin
            fail_cnt++;
            $error("bit_out[%0d] differs from sampled stream", i);
         end

      a_pulse_locked: assert property (@(posedge clk) disable iff (rst)
                                       bit_valid[i] |-> locked[i])
         else begin
            fail_cnt++;
            $error("bit_valid[%0d] while not locked", i);
         end

      a_stag_window: assert property (@(posedge clk) disable iff (rst)
                                      $changed(stag_out[i]) |-> ($past(ce)
                                      && $past(tick) >= FIRST_TAKE && $past(tick) <= LAST_TAKE))
         else begin
            fail_cnt++;
            $error("stag_out[%0d] moved outside the take range", i);
         end
   end

endmodule

bind acquire_top acquire_assertions acquire_assertions_inst (
   .clk       (clk),
   .rst       (rst),
   .ce        (ce),
   .tick      (tick),
   .stag_out  (stag_out),
   .bit_out   (bit_out),
   .bit_valid (bit_valid),
   .locked    (locked)
);

// File: tb/acquire_tb.sv
`timescale 1ns/1ps
`include "acq_macros.svh"

module acquire_tb;

   localparam int NA      = `ACQ_NUM_ANT;
   localparam int WINDOWS = 40;   // Windows per phase
   localparam int PHASES  = 6;
   localparam int LIMIT   = PHASES * (WINDOWS * `ACQ_WINDOW * 2 + 10) + 500;

   logic                            clk = 1'b0;
   logic                            rst;
   logic                            ce;
   acq_signal_pkg::ant_bits_t       ant_in;
   acq_signal_pkg::phase_t [NA-1:0] cfg_offset;
   logic                            jitter_en;
   acq_signal_pkg::ant_bits_t       stag_out;
   acq_signal_pkg::ant_bits_t       bit_out;
   acq_signal_pkg::ant_bits_t       bit_valid;
   acq_signal_pkg::ant_bits_t       locked;

   // --------------------
   // Reference state
   // --------------------
   logic [31:0]               lfsr = 32'h112d;
   int                        errors = 0;
   int                        cycles = 0;
   int                        assert_fails;
   string                     test_name;
   int                        tb_tick;     // Mirror of the DUT window counter
   int                        tb_win;
   logic                      last_ce;     // What the DUT took at the latest edge
   int                        last_tick;
   int                        last_win;
   acq_signal_pkg::ant_bits_t last_ant;
   acq_signal_pkg::ant_bits_t sym;         // Symbols of the current window
   acq_signal_pkg::ant_bits_t prev_stag;
   acq_signal_pkg::ant_bits_t prev_bit;
   acq_signal_pkg::ant_bits_t prev_locked;
   logic [63:0]               sym_hist [NA]; // Sent symbols by window
   int                        offs [NA];
   logic                      jit;
   int                        lag [NA];
   int                        rec_cnt [NA];
   int                        first_win [NA];
   int                        pulse_win [NA];
   logic [2:0]                first_bits [NA];

   acquire_top acquire_top_inst (
      .clk (clk), .rst (rst), .ce (ce), .ant_in (ant_in), .cfg_offset (cfg_offset),
      .jitter_en (jitter_en), .stag_out (stag_out), .bit_out (bit_out),
      .bit_valid (bit_valid), .locked (locked)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("Timeout after %0d cycles, the run did not finish", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic take_bit();
      logic b;
      b    = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      return b;
   endfunction

   task automatic pick_symbols(input int w);
      logic b;
      for (int i = 0; i < NA; i++) begin
         b = take_bit();
         // Never three equal symbols in a row
         if (w >= 2 && sym_hist[i][w-1] == sym_hist[i][w-2] && b == sym_hist[i][w-1])
            b = ~b;
         sym[i]         = b;
         sym_hist[i][w] = b;
      end
   endtask

   // Repeats of at most two leave only one of lag 0 and lag 1 to fit
   function automatic int find_lag(input int i);
      int w;
      for (int l = 0; l < 2; l++) begin
         w = first_win[i] - l;
         if (first_bits[i] == {sym_hist[i][w+2], sym_hist[i][w+1], sym_hist[i][w]})
            return l;
      end
      return -1;
   endfunction

   task automatic check_bit(input int i);
      if (rec_cnt[i] > 0) begin
         assert (last_win == pulse_win[i] + 1) else begin
            errors++;
            $display("Error %s bit_valid[%0d] window: expected %0d, actual %0d",
                     test_name, i, pulse_win[i] + 1, last_win);
         end
      end
      pulse_win[i] = last_win;
      if (rec_cnt[i] < 3) begin
         if (rec_cnt[i] == 0) first_win[i] = last_win;
         first_bits[i][rec_cnt[i]] = bit_out[i];
         if (rec_cnt[i] == 2) begin
            lag[i] = find_lag(i);
            assert (lag[i] >= 0) else begin
               errors++;
               lag[i] = 0;
               $display("Error %s: antenna %0d first three bits fit no constant lag",
                        test_name, i);
            end
         end
      end else begin
         assert (bit_out[i] == sym_hist[i][last_win - lag[i]]) else begin
            errors++;
            $display("Error %s bit_out[%0d]: expected %b, actual %b", test_name, i,
                     sym_hist[i][last_win - lag[i]], bit_out[i]);
         end
      end
      rec_cnt[i]++;
   endtask

   // Checks the result of the latest edge
   task automatic observe();
      int exp_tick;
      for (int i = 0; i < NA; i++) begin
         exp_tick = `ACQ_SAMPLE_PHASE - offs[i];
         if (stag_out[i] != prev_stag[i]) begin
            assert (last_ce && (last_tick == exp_tick || (jit && last_tick == exp_tick - 1)))
            else begin
               errors++;
               $display("Error %s stag_out[%0d] tick: expected %0d, actual %0d",
                        test_name, i, exp_tick, last_tick);
            end
         end
         if (last_ce && !jit && last_tick == exp_tick) begin
            assert (stag_out[i] == last_ant[i]) else begin
               errors++;
               $display("Error %s stag_out[%0d]: expected %b, actual %b",
                        test_name, i, last_ant[i], stag_out[i]);
            end
         end
         if (bit_valid[i]) check_bit(i);
      end
      if (!last_ce) begin
         assert (stag_out == prev_stag && bit_out == prev_bit && locked == prev_locked
                 && bit_valid == '0) else begin
            errors++;
            $display("Error %s: an output changed on a cycle without ce", test_name);
         end
      end
      prev_stag   = stag_out;
      prev_bit    = bit_out;
      prev_locked = locked;
   endtask

   task automatic step_cycle(input logic ce_v);
      @(posedge clk);
      #0.5;
      observe();
      ce        = ce_v;
      ant_in    = sym;
      last_ce   = ce_v;
      last_tick = tb_tick;
      last_win  = tb_win;
      last_ant  = sym;
      if (ce_v) begin
         tb_tick = (tb_tick == `ACQ_WINDOW - 1) ? 0 : tb_tick + 1;
         if (tb_tick == 0) tb_win++;
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #0.5;
      rst = 1'b1;
      ce  = 1'b0;
      for (int i = 0; i < NA; i++) cfg_offset[i] = acq_signal_pkg::phase_t'(offs[i]);
      jitter_en = jit;
      repeat (2) @(posedge clk);
      #0.5;
      rst = 1'b0;
      @(posedge clk);
      #0.5;
      // Out of reset and no ce yet
      assert (stag_out == '0 && bit_out == '0 && bit_valid == '0 && locked == '0) else begin
         errors++;
         $display("Error %s reset: expected all outputs 0, actual %b %b %b %b", test_name,
                  stag_out, bit_out, bit_valid, locked);
      end
      tb_tick     = 0;
      tb_win      = 0;
      last_ce     = 1'b0;
      prev_stag   = '0;
      prev_bit    = '0;
      prev_locked = '0;
      sym         = '0;
   endtask

   // --------------------
   // Phases
   // --------------------
   task automatic run_phase(input int p);
      logic stall;
      int   base;
      stall     = (p >= 4);    // ce on every other cycle
      base      = p % 2;
      jit       = (p == 2 || p == 3 || p == 5);
      test_name = $sformatf("%s_%s_%0d", stall ? "stall" : "run", jit ? "jitter" : "fixed", base);
      for (int i = 0; i < NA; i++) begin
         offs[i]    = (i + base) % (`ACQ_MAX_OFFSET + 1);
         rec_cnt[i] = 0;
      end
      apply_reset();
      for (int w = 0; w < WINDOWS; w++) begin
         pick_symbols(w);
         for (int t = 0; t < `ACQ_WINDOW; t++) begin
            if (stall) step_cycle(1'b0);
            step_cycle(1'b1);
            if (w == 8 && t == 0) begin
               assert (locked == '1) else begin
                  errors++;
                  $display("Error %s lock: expected %b, actual %b", test_name,
                           {NA{1'b1}}, locked);
               end
            end
         end
      end
      step_cycle(1'b0);        // Last ce of the phase
      for (int i = 0; i < NA; i++) begin
         assert (rec_cnt[i] >= 30) else begin
            errors++;
            $display("Error %s recovered bits on %0d: expected 30 or more, actual %0d",
                     test_name, i, rec_cnt[i]);
         end
      end
   endtask

   initial begin
      rst        = 1'b1;
      ce         = 1'b0;
      ant_in     = '0;
      cfg_offset = '0;
      jitter_en  = 1'b0;
      sym        = '0;
      for (int p = 0; p < PHASES; p++) run_phase(p);
      assert_fails = acquire_top_inst.acquire_assertions_inst.fail_cnt;
      $display("Done with %0d compare errors and %0d assertion failures", errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: files.f
+incdir+include
hdl/acq_signal_pkg.sv
hdl/acq_ctrl_pkg.sv
hdl/jitter_lfsr.sv
hdl/signal_stagger.sv
hdl/edge_phase_tracker.sv
hdl/acquire_top.sv
tb/acquire_assertions.sv
tb/acquire_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= acquire_tb
FILELIST  ?= files.f
BUILD     ?= obj_dir
RUNFLAGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
